//--- logic/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    ////////////////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W      = 32;
    localparam int INSTR_W     = 32;
    localparam int FETCH_WIDTH = 2;     // instructions per fetch cycle

    ////////////////////////////////////////////////////////////////////////
    // fetch line geometry
    ////////////////////////////////////////////////////////////////////////

    localparam int LINE_BYTES = 16;
    localparam int LINE_WORDS = LINE_BYTES / (INSTR_W / 8);
    localparam int WORD_IDX_W = $clog2(LINE_WORDS);     // pc bits 3..2

    // only one slot left in the line once the pc reaches this word
    localparam logic [WORD_IDX_W-1:0] LINE_LAST_WORD = WORD_IDX_W'(LINE_WORDS - 1);

    ////////////////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////////////////

    // request to the instruction memory, data follows one cycle later
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;    // word aligned
    } imem_req_t;

    // one fetch group as it sits in the instruction buffer
    typedef struct packed {
        logic [ADDR_W-1:0]      pc;         // address of slot 0
        logic [INSTR_W-1:0]     instr0;
        logic [INSTR_W-1:0]     instr1;     // zero when slot 1 unused
        logic [FETCH_WIDTH-1:0] slot_valid; // bit 0 is slot 0
    } fetch_packet_t;

endpackage

`default_nettype wire

//--- logic/fetch_pc.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_pc #(
    parameter logic [frontend_pkg::ADDR_W-1:0] RESET_PC = 32'h1c00_0000
) (
    input  logic                            clk,
    input  logic                            i_rst,
    input  logic                            i_stall,        // instruction buffer nearly full
    input  logic                            i_redirect,
    input  logic [frontend_pkg::ADDR_W-1:0] i_redirect_pc,
    output frontend_pkg::imem_req_t         o_req
);

    localparam int AW = frontend_pkg::ADDR_W;

    logic [AW-1:0]                       pc;
    logic [AW-1:0]                       pc_next;
    logic [frontend_pkg::WORD_IDX_W-1:0] word_idx;
    logic                                running;   // low until reset is released
    logic                                issue;

    assign word_idx = pc[frontend_pkg::WORD_IDX_W+1:2];

    // no request while redirecting, the target goes out next cycle
    assign issue = running & ~i_stall & ~i_redirect;

    assign o_req.valid = issue;
    assign o_req.addr  = pc;

    // next pc prediction
    // step over the words left in the line, at most one fetch width
    always_comb begin
        int slots;
        slots = int'(frontend_pkg::LINE_LAST_WORD) - int'(word_idx) + 1;
        if (slots > frontend_pkg::FETCH_WIDTH) begin
            slots = frontend_pkg::FETCH_WIDTH;
        end
        pc_next = pc + AW'(slots * 4);
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            running <= 1'b0;
            pc      <= RESET_PC;
        end else begin
            running <= 1'b1;
            if (i_redirect) begin
                pc <= {i_redirect_pc[AW-1:2], 2'b00};   // force word alignment
            end else if (issue) begin
                pc <= pc_next;
            end
            // stalled or idle, pc holds
        end
    end

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input  logic                                                   clk,
    input  logic                                                   i_rst,
    input  frontend_pkg::imem_req_t                                i_req,
    input  logic                                                   i_flush,
    input  logic [frontend_pkg::FETCH_WIDTH*frontend_pkg::INSTR_W-1:0] i_rdata,
    output logic                                                   o_wr,
    output frontend_pkg::fetch_packet_t                            o_pkt
);

    localparam int FW = frontend_pkg::FETCH_WIDTH;
    localparam int IW = frontend_pkg::INSTR_W;

    logic                                req_valid_q;   // request from last cycle
    logic [frontend_pkg::ADDR_W-1:0]     req_pc_q;
    logic [frontend_pkg::WORD_IDX_W-1:0] word_idx;
    logic [FW-1:0]                       slot_valid;
    logic [IW-1:0]                       slot_word [FW];

    ////////////////////////////////////////////////////////////////////////
    // request register
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_rst) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= i_req.valid & ~i_flush;
        end
    end

    always_ff @(posedge clk) begin
        req_pc_q <= i_req.addr;
    end

    ////////////////////////////////////////////////////////////////////////
    // packet forming
    ////////////////////////////////////////////////////////////////////////

    assign word_idx = req_pc_q[frontend_pkg::WORD_IDX_W+1:2];

    // a slot is usable while it stays inside the fetch line
    always_comb begin
        for (int k = 0; k < FW; k++) begin
            slot_valid[k] = (int'(word_idx) + k) <= int'(frontend_pkg::LINE_LAST_WORD);
            slot_word[k]  = slot_valid[k] ? i_rdata[k*IW +: IW] : '0;
        end
    end

    always_comb begin
        o_pkt.pc         = req_pc_q;
        o_pkt.instr0     = slot_word[0];
        o_pkt.instr1     = slot_word[1];
        o_pkt.slot_valid = slot_valid;
    end

    // the in-flight packet dies with a redirect
    assign o_wr = req_valid_q & ~i_flush;

endmodule

`default_nettype wire

//--- logic/instr_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module instr_buffer #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic                        i_flush,
    input  logic                        i_wr,
    input  frontend_pkg::fetch_packet_t i_wr_pkt,
    input  logic                        i_take,
    output logic                        o_valid,
    output frontend_pkg::fetch_packet_t o_pkt,
    output logic                        o_full
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(BUF_DEPTH);
    localparam logic [CNT_W-1:0] CNT_HIGH = CNT_W'(BUF_DEPTH - 1);  // room for one in flight

    frontend_pkg::fetch_packet_t mem [BUF_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    ////////////////////////////////////////////////////////////////////////
    // status and head
    ////////////////////////////////////////////////////////////////////////

    assign o_valid = (count != '0);
    assign o_full  = (count >= CNT_HIGH);
    assign o_pkt   = mem[rd_ptr];

    // take on an empty buffer is ignored
    assign do_pop = i_take & o_valid & ~i_flush;

    // a write into a truly full buffer only lands if the head leaves too
    assign do_push = i_wr & ~i_flush & ((count != CNT_MAX) | do_pop);

    ////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_wr_pkt;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);   // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;        // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/frontend_top.sv
`timescale 1ns/10ps
`default_nettype none

module frontend_top #(
    parameter logic [frontend_pkg::ADDR_W-1:0] RESET_PC  = 32'h1c00_0000,
    parameter int                              BUF_DEPTH = 8
) (
    input  logic                                                   clk,
    input  logic                                                   i_rst,

    // instruction memory, fixed one cycle read latency
    output frontend_pkg::imem_req_t                                o_imem_req,
    input  logic [frontend_pkg::FETCH_WIDTH*frontend_pkg::INSTR_W-1:0] i_imem_rdata,

    // branch redirect from execute
    input  logic                                                   i_redirect,
    input  logic [frontend_pkg::ADDR_W-1:0]                        i_redirect_pc,

    // packets to the consumer
    output logic                                                   o_pkt_valid,
    output frontend_pkg::fetch_packet_t                            o_pkt,
    input  logic                                                   i_take
);

    frontend_pkg::imem_req_t     fetch_req;
    frontend_pkg::fetch_packet_t stage_pkt;
    logic                        stage_wr;
    logic                        buf_full;
    logic                        flush;
    logic                        stall;

    assign flush = i_redirect;  // redirect kills everything younger
    assign stall = buf_full;

    assign o_imem_req = fetch_req;

    ////////////////////////////////////////////////////////////////////////
    // fetch pc
    ////////////////////////////////////////////////////////////////////////

    fetch_pc #(
        .RESET_PC      (RESET_PC)
    ) u_fetch_pc (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_stall       (stall),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_req         (fetch_req)
    );

    ////////////////////////////////////////////////////////////////////////
    // pc and memory words meet here
    ////////////////////////////////////////////////////////////////////////

    fetch_stage u_fetch_stage (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_req   (fetch_req),
        .i_flush (flush),
        .i_rdata (i_imem_rdata),
        .o_wr    (stage_wr),
        .o_pkt   (stage_pkt)
    );

    ////////////////////////////////////////////////////////////////////////
    // instruction buffer
    ////////////////////////////////////////////////////////////////////////

    instr_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_instr_buffer (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_flush   (flush),
        .i_wr      (stage_wr),
        .i_wr_pkt  (stage_pkt),
        .i_take    (i_take),
        .o_valid   (o_pkt_valid),
        .o_pkt     (o_pkt),
        .o_full    (buf_full)  // back to fetch as stall
    );

endmodule

`default_nettype wire

//--- sim/frontend_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module frontend_assertions #(
    parameter int BUF_DEPTH = 8
) (
    input logic                         clk,
    input logic                         i_rst,
    input frontend_pkg::imem_req_t      i_req,
    input logic [$clog2(BUF_DEPTH):0]   i_buf_count,
    input logic                         i_redirect,
    input logic                         i_take,
    input logic                         i_pkt_valid
);

    ////////////////////////////////////////////////////////////////////////
    // fetch flow control
    ////////////////////////////////////////////////////////////////////////

    // one entry must stay free for the packet in flight
    property no_req_when_full;
        @(posedge clk) disable iff (i_rst)
            i_req.valid |=> (int'(i_buf_count) < BUF_DEPTH) || i_redirect
                            || (i_take && i_pkt_valid);
    endproperty

    // redirect empties the buffer and kills the in-flight packet
    property empty_after_redirect;
        @(posedge clk) disable iff (i_rst)
            i_redirect |=> !i_pkt_valid;
    endproperty

    // state is unknown before the first edge
    property quiet_in_reset;
        @(posedge clk)
            (i_rst && $past(i_rst)) |-> !i_pkt_valid;
    endproperty

    a_no_req_when_full: assert property (no_req_when_full)
        else $error("fetch request issued while the instruction buffer is full");

    a_empty_after_redirect: assert property (empty_after_redirect)
        else $error("packet still valid in the cycle after a redirect");

    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("packet valid while reset is held");

endmodule

bind frontend_top frontend_assertions #(
    .BUF_DEPTH   (BUF_DEPTH)
) u_assertions (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_req       (o_imem_req),
    .i_buf_count (u_instr_buffer.count),
    .i_redirect  (i_redirect),
    .i_take      (i_take),
    .i_pkt_valid (o_pkt_valid)
);

`default_nettype wire

//--- sim/frontend_tb.sv
`timescale 1ns/10ps
`default_nettype none

module frontend_tb;

    localparam logic [31:0] RESET_PC     = 32'h1c00_0000;
    localparam int          BUF_DEPTH    = 8;
    localparam int          RESET_CYCLES = 10;
    localparam int          RAND_CYCLES  = 400;
    localparam int          HOLD_CYCLES  = 3 * BUF_DEPTH;
    localparam int          DRAIN_CYCLES = 40;
    localparam int          PLAN_CYCLES  = RESET_CYCLES + 2 * RAND_CYCLES + HOLD_CYCLES
                                           + DRAIN_CYCLES;
    localparam int          MIN_TAKEN    = 300;
    localparam logic [31:0] WORD_PATTERN = 32'h5a3c_96e1;  // memory contents

    logic                        clk;
    logic                        i_rst;
    frontend_pkg::imem_req_t     o_imem_req;
    logic [63:0]                 i_imem_rdata;
    logic                        i_redirect;
    logic [31:0]                 i_redirect_pc;
    logic                        o_pkt_valid;
    frontend_pkg::fetch_packet_t o_pkt;
    logic                        i_take;

    logic [15:0]                 lfsr;
    frontend_pkg::imem_req_t     mem_req_q;     // request seen by the memory
    logic [31:0]                 exp_pc;        // pc of the next packet taken
    logic [1:0]                  exp_slots;
    logic                        rst_seen = 1'b0;
    int                          taken = 0;

    frontend_top #(
        .RESET_PC      (RESET_PC),
        .BUF_DEPTH     (BUF_DEPTH)
    ) dut (
        .clk           (clk),
        .i_rst         (i_rst),
        .o_imem_req    (o_imem_req),
        .i_imem_rdata  (i_imem_rdata),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_pkt_valid   (o_pkt_valid),
        .o_pkt         (o_pkt),
        .i_take        (i_take)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////

    // instruction word stored at an address
    function automatic logic [31:0] instr_at(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ WORD_PATTERN;
        return {x[24:0], x[31:25]};
    endfunction

    // last word of a 16 byte line leaves room for one slot only
    function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc);
        return (pc[3:2] == 2'd3) ? pc + 32'd4 : pc + 32'd8;
    endfunction

    function automatic logic [1:0] slot_mask(input logic [31:0] pc);
        return (pc[3:2] == 2'd3) ? 2'b01 : 2'b11;
    endfunction

    assign exp_slots = slot_mask(exp_pc);

    // fibonacci lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);     // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // memory model with one cycle read latency
    ////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        mem_req_q <= o_imem_req;
    end

    always @(negedge clk) begin
        if (mem_req_q.valid) begin
            i_imem_rdata = {instr_at(mem_req_q.addr + 32'd4), instr_at(mem_req_q.addr)};
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // checker
    ////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (i_rst) begin
            if (rst_seen) begin
                check_value(64'(o_pkt_valid), 64'd0, "o_pkt_valid during reset");
                check_value(64'(o_imem_req.valid), 64'd0, "request during reset");
            end
            rst_seen <= 1'b1;
            exp_pc   <= RESET_PC;
        end else if (i_redirect) begin
            exp_pc <= i_redirect_pc;        // a take in this cycle is dropped
        end else if (i_take && o_pkt_valid) begin
            check_value(64'(o_pkt.pc), 64'(exp_pc), "packet pc");
            check_value(64'(o_pkt.slot_valid), 64'(exp_slots), "slot_valid");
            check_value(64'(o_pkt.instr0), 64'(instr_at(exp_pc)), "instr0");
            if (exp_slots[1]) begin
                check_value(64'(o_pkt.instr1), 64'(instr_at(exp_pc + 32'd4)), "instr1");
            end
            taken  <= taken + 1;
            exp_pc <= next_fetch_pc(exp_pc);
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////

    task automatic random_phase(input int cycles);
        logic [31:0] r;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            rand_bits(2, r);
            i_take = (r[1:0] != 2'b00);     // take three cycles in four
            rand_bits(5, r);
            i_redirect = (c >= 20) && (r[4:0] == 5'd0);
            rand_bits(8, r);
            i_redirect_pc = RESET_PC + {22'd0, r[7:0], 2'b00};
        end
    endtask

    initial begin
        lfsr          = 16'd92;
        i_rst         = 1'b1;
        i_take        = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = RESET_PC;
        i_imem_rdata  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        i_rst = 1'b0;

        random_phase(RAND_CYCLES);

        // consumer stalls so the buffer fills and fetch stops
        @(negedge clk);
        i_take     = 1'b0;
        i_redirect = 1'b0;
        repeat (HOLD_CYCLES) @(negedge clk);
        check_value(64'(o_imem_req.valid), 64'd0, "request with buffer full");
        check_value(64'(o_pkt_valid), 64'd1, "o_pkt_valid with buffer full");

        random_phase(RAND_CYCLES);

        @(negedge clk);
        i_take     = 1'b1;
        i_redirect = 1'b0;
        repeat (DRAIN_CYCLES) @(negedge clk);

        if (taken < MIN_TAKEN) begin
            $display("only %0d packets were taken, expected at least %0d", taken, MIN_TAKEN);
            $display("sim failed");
            $fatal(1, "too few packets");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

    initial begin
        #(20 * PLAN_CYCLES * 10);
        $display("watchdog: the run did not finish within %0d cycles", 20 * PLAN_CYCLES);
        $display("sim failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- project.f
logic/frontend_pkg.sv
logic/fetch_pc.sv
logic/fetch_stage.sv
logic/instr_buffer.sv
logic/frontend_top.sv
sim/frontend_assertions.sv
sim/frontend_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module frontend_tb -f project.f \
    --Mdir obj_dir -o frontend_sim > "$LOG" 2>&1 \
    && ./obj_dir/frontend_sim >> "$LOG" 2>&1 \
    || echo "build or simulation returned an error" >> "$LOG"

cat "$LOG"

grep -qx "sim passed" "$LOG" && echo "result: PASS" \
    || { echo "result: FAIL"; exit 1; }
